// File: hdl/mem_pkg.sv
// Tagged memory bus types

package mem_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int TAG_W  = 4;   // up to 15 tags, 0 is reserved
	localparam int DATA_W = 64;  // one processor bus word

	////////////////////
	// bus encodings
	////////////////////

	// command on the processor side, none means idle cycle
	typedef enum logic [1:0] {
		bus_none  = 2'd0,
		bus_load  = 2'd1,
		bus_store = 2'd2
	} bus_command_t;

	// access width of a load or store
	typedef enum logic [1:0] {
		size_byte   = 2'd0,
		size_half   = 2'd1,
		size_word   = 2'd2,
		size_double = 2'd3
	} mem_size_t;

	////////////////////
	// payload types
	////////////////////

	typedef logic [TAG_W-1:0]  mem_tag_t;   // 0 = no transaction
	typedef logic [DATA_W-1:0] mem_data_t;  // load and store data

endpackage

// File: hdl/line_store.sv
// Data line array

`timescale 1ns/100ps

module line_store #(
	parameter int LINES  = 64,
	parameter int ADDR_W = 16
) (
	input  logic                clk,
	input  logic [ADDR_W-1:0]   proc_addr,
	input  mem_pkg::mem_size_t  proc_size,
	input  mem_pkg::mem_data_t  proc_data,
	input  logic                store_en,
	output logic                addr_ok,
	output mem_pkg::mem_data_t  rd_data
);

	import mem_pkg::*;

	// line index width, kept at one bit for a single-line array
	localparam int LINE_W = (LINES > 1) ? $clog2(LINES) : 1;
	localparam logic [ADDR_W:0] BYTES = (ADDR_W + 1)'(LINES * 8);

	mem_data_t         lines [LINES];  // one entry per 64-bit line
	mem_data_t         cur_line;
	mem_data_t         merged;
	logic [LINE_W-1:0] line_idx;
	logic [2:0]        byte_off;

	////////////////////
	// address decode
	////////////////////

	assign addr_ok  = {1'b0, proc_addr} < BYTES;
	assign line_idx = proc_addr[LINE_W+2:3];
	assign byte_off = proc_addr[2:0];  // low bits under the size are ignored
	assign cur_line = lines[line_idx];

	////////////////////
	// store merge
	////////////////////

	// only the lane picked by size and offset changes
	always_comb begin
		merged = cur_line;
		case (proc_size)
			size_byte: begin
				merged[8*byte_off +: 8] = proc_data[7:0];
			end
			size_half: begin
				merged[16*byte_off[2:1] +: 16] = proc_data[15:0];
			end
			size_word: begin
				merged[32*byte_off[2] +: 32] = proc_data[31:0];
			end
			default: begin
				merged = proc_data;  // full double
			end
		endcase
	end

	// store_en already includes the range check from the tag pool
	always_ff @(posedge clk) begin
		if (store_en) begin
			lines[line_idx] <= merged;
		end
	end

	////////////////////
	// load lane select
	////////////////////

	// zero-extended lane of the addressed line
	always_comb begin
		case (proc_size)
			size_byte: begin
				rd_data = {56'd0, cur_line[8*byte_off +: 8]};
			end
			size_half: begin
				rd_data = {48'd0, cur_line[16*byte_off[2:1] +: 16]};
			end
			size_word: begin
				rd_data = {32'd0, cur_line[32*byte_off[2] +: 32]};
			end
			default: begin
				rd_data = cur_line;
			end
		endcase
	end

endmodule

// File: hdl/tag_pool.sv
// Tag allocation and return scheduling

`timescale 1ns/100ps

module tag_pool #(
	parameter int NUM_TAGS = 4,
	parameter int LATENCY  = 6
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  mem_pkg::bus_command_t proc_command,
	input  logic                  addr_ok,
	output mem_pkg::mem_tag_t     grant_tag,
	output logic                  store_en,
	output mem_pkg::mem_tag_t     mem_response,
	output mem_pkg::mem_tag_t     bus_tag
);

	import mem_pkg::*;

	localparam int CNT_W = $clog2(LATENCY + 1);

	logic [CNT_W-1:0] count [1:NUM_TAGS];  // cycles left on each tag
	logic [NUM_TAGS:1] waiting;            // load still owes its data
	logic [NUM_TAGS:1] idle;
	logic [NUM_TAGS:1] ready;
	logic              accept_req;
	mem_tag_t          ret_tag;

	////////////////////
	// tag state decode
	////////////////////

	always_comb begin
		for (int i = 1; i <= NUM_TAGS; i++) begin
			idle[i]  = (count[i] == '0) && !waiting[i];
			// counter hits zero at this edge, or already sits there behind another load
			ready[i] = waiting[i] && (count[i] <= CNT_W'(1));
		end
	end

	assign accept_req = ((proc_command == bus_load) || (proc_command == bus_store)) && addr_ok;

	// lowest idle tag wins, walk down so the last hit is the lowest
	always_comb begin
		grant_tag = '0;
		for (int i = NUM_TAGS; i >= 1; i--) begin
			if (accept_req && idle[i]) begin
				grant_tag = mem_tag_t'(i);
			end
		end
	end

	assign store_en = (grant_tag != '0) && (proc_command == bus_store);

	// one load per cycle on the data bus, lowest tag first
	always_comb begin
		ret_tag = '0;
		for (int i = NUM_TAGS; i >= 1; i--) begin
			if (ready[i]) begin
				ret_tag = mem_tag_t'(i);
			end
		end
	end

	////////////////////
	// per-tag counters
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i <= NUM_TAGS; i++) begin
				count[i]   <= '0;
				waiting[i] <= 1'b0;
			end
		end else begin
			for (int i = 1; i <= NUM_TAGS; i++) begin
				if (grant_tag == mem_tag_t'(i)) begin
					count[i]   <= CNT_W'(LATENCY);
					waiting[i] <= (proc_command == bus_load);  // stores owe nothing
				end else begin
					if (count[i] != '0) begin
						count[i] <= count[i] - CNT_W'(1);
					end
					if (ret_tag == mem_tag_t'(i)) begin
						waiting[i] <= 1'b0;  // free again after this edge
					end
				end
			end
		end
	end

	////////////////////
	// bus outputs
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_response <= '0;
			bus_tag      <= '0;
		end else begin
			mem_response <= grant_tag;  // 0 when the command was refused
			bus_tag      <= ret_tag;
		end
	end

endmodule

// File: hdl/load_buffer.sv
// Load data holding slots

`timescale 1ns/100ps

module load_buffer #(
	parameter int NUM_TAGS = 4
) (
	input  logic               clk,
	input  logic               arst_n,
	input  mem_pkg::mem_tag_t  grant_tag,
	input  logic               load_en,
	input  mem_pkg::mem_data_t rd_data,
	input  mem_pkg::mem_tag_t  bus_tag,
	output mem_pkg::mem_data_t mem_data
);

	import mem_pkg::*;

	mem_data_t         slot [1:NUM_TAGS];  // data captured at acceptance
	logic [NUM_TAGS:1] full;               // slot holds data not yet returned

	always_ff @(posedge clk) begin
		if (load_en) begin
			slot[grant_tag] <= rd_data;
		end
	end

	// a new capture wins over the return of the same tag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= '0;
		end else begin
			for (int i = 1; i <= NUM_TAGS; i++) begin
				if (load_en && (grant_tag == mem_tag_t'(i))) begin
					full[i] <= 1'b1;
				end else if (bus_tag == mem_tag_t'(i)) begin
					full[i] <= 1'b0;
				end
			end
		end
	end

	// read from the slot registers so data lines up with the registered tag
	assign mem_data = ((bus_tag != '0) && full[bus_tag]) ? slot[bus_tag] : '0;

endmodule

// File: hdl/tagged_mem.sv
// Tagged pipelined data memory

`timescale 1ns/100ps

module tagged_mem #(
	parameter int NUM_TAGS = 4,   // 1 to 15
	parameter int LATENCY  = 6,   // at least 1
	parameter int LINES    = 64,
	parameter int ADDR_W   = 16
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [ADDR_W-1:0]     proc_addr,
	input  mem_pkg::mem_data_t    proc_data,
	input  mem_pkg::mem_size_t    proc_size,
	input  mem_pkg::bus_command_t proc_command,
	output mem_pkg::mem_tag_t     mem_response,
	output mem_pkg::mem_data_t    mem_data,
	output mem_pkg::mem_tag_t     mem_tag
);

	import mem_pkg::*;

	logic      addr_ok;
	logic      store_en;
	logic      load_en;
	mem_data_t rd_data;
	mem_tag_t  grant_tag;
	mem_tag_t  bus_tag;

	////////////////////
	// array
	////////////////////

	line_store #(
		.LINES  (LINES),
		.ADDR_W (ADDR_W)
	) u_line_store (
		.clk       (clk),
		.proc_addr (proc_addr),
		.proc_size (proc_size),
		.proc_data (proc_data),
		.store_en  (store_en),
		.addr_ok   (addr_ok),
		.rd_data   (rd_data)
	);

	////////////////////
	// tags
	////////////////////

	tag_pool #(
		.NUM_TAGS (NUM_TAGS),
		.LATENCY  (LATENCY)
	) u_tag_pool (
		.clk          (clk),
		.arst_n       (arst_n),
		.proc_command (proc_command),
		.addr_ok      (addr_ok),
		.grant_tag    (grant_tag),
		.store_en     (store_en),
		.mem_response (mem_response),
		.bus_tag      (bus_tag)
	);

	// any granted command that is not a store is a load
	assign load_en = (grant_tag != '0) && !store_en;

	load_buffer #(
		.NUM_TAGS (NUM_TAGS)
	) u_load_buffer (
		.clk       (clk),
		.arst_n    (arst_n),
		.grant_tag (grant_tag),
		.load_en   (load_en),
		.rd_data   (rd_data),
		.bus_tag   (bus_tag),
		.mem_data  (mem_data)
	);

	assign mem_tag = bus_tag;  // tag that goes with mem_data

endmodule

// File: tb/tagged_mem_tb.sv
// Tagged memory testbench

`timescale 1ns/100ps

module tagged_mem_tb;

	import mem_pkg::*;

	localparam int NUM_TAGS  = 4;
	localparam int LATENCY   = 6;
	localparam int LINES     = 64;
	localparam int ADDR_W    = 16;
	localparam int MAX_RETRY = 4 * NUM_TAGS * LATENCY;  // cycles one command may stay refused
	localparam int DRAIN_MAX = 4 * NUM_TAGS * LATENCY;

	logic              clk = 1'b0;
	logic              arst_n;
	logic [ADDR_W-1:0] proc_addr;
	mem_data_t         proc_data;
	mem_size_t         proc_size;
	bus_command_t      proc_command;
	mem_tag_t          mem_response;
	mem_data_t         mem_data;
	mem_tag_t          mem_tag;

	////////////////////
	// scoreboard
	////////////////////

	// indexed by tag, loads counted at acceptance and at return
	int        load_cnt     [16] = '{default: 0};
	int        return_cnt   [16] = '{default: 0};   // only the return monitor writes this
	int        accept_cycle [16] = '{default: -100};
	logic      is_load      [16] = '{default: 1'b0};
	mem_data_t exp_data     [16];
	int        cycle_cnt  = 0;
	int        refusals   = 0;  // refused while every tag was busy

	tagged_mem #(
		.NUM_TAGS (NUM_TAGS),
		.LATENCY  (LATENCY),
		.LINES    (LINES),
		.ADDR_W   (ADDR_W)
	) DUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.proc_addr    (proc_addr),
		.proc_data    (proc_data),
		.proc_size    (proc_size),
		.proc_command (proc_command),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag)
	);

	always #5 clk = ~clk;
	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;  // edges seen so far

	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_tag(input string name, input mem_tag_t actual, input mem_tag_t expected);
		if (actual !== expected) begin
			$display("Fail at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_data(input string name, input mem_data_t actual,
			input mem_data_t expected);
		if (actual !== expected) begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	// a load tag frees on its return, a store tag once its latency has run out
	function automatic logic tag_is_free(input int t);
		if (is_load[t]) begin
			return load_cnt[t] == return_cnt[t];
		end
		return (cycle_cnt - accept_cycle[t]) > LATENCY;
	endfunction

	function automatic mem_tag_t lowest_free_tag();
		for (int t = 1; t <= NUM_TAGS; t++) begin
			if (tag_is_free(t)) begin
				return mem_tag_t'(t);
			end
		end
		return '0;
	endfunction

	function automatic int loads_outstanding();
		int n;
		n = 0;
		for (int t = 1; t <= NUM_TAGS; t++) begin
			n += load_cnt[t] - return_cnt[t];
		end
		return n;
	endfunction

	////////////////////
	// return monitor
	////////////////////

	// sampled mid-cycle, away from the edge where the bus registers change
	always @(negedge clk) begin
		if (mem_tag == '0) begin
			check_data("mem_data", mem_data, '0);
		end else if (int'(mem_tag) > NUM_TAGS || !is_load[mem_tag]
				|| load_cnt[mem_tag] == return_cnt[mem_tag]) begin
			$display("At %0t tag %0d came back on mem_tag with no load outstanding",
				$time, mem_tag);
			stop_with_failure();
		end else if (cycle_cnt - accept_cycle[mem_tag] < LATENCY) begin
			$display("At %0t tag %0d came back after only %0d cycles", $time, mem_tag,
				cycle_cnt - accept_cycle[mem_tag]);
			stop_with_failure();
		end else begin
			check_data("mem_data", mem_data, exp_data[mem_tag]);
			return_cnt[mem_tag] = return_cnt[mem_tag] + 1;
		end
	end

	// one command, reissued each cycle while it is refused for lack of a tag
	task automatic issue_command(input int cmd_v, input int size_v, input int addr_v,
			input mem_data_t wdata, input mem_data_t expected);
		bus_command_t cmd;
		logic         valid;
		logic         done;
		mem_tag_t     want;
		int           t;
		int           tries;

		cmd   = bus_command_t'(cmd_v[1:0]);
		valid = ((cmd == bus_load) || (cmd == bus_store)) && (addr_v < LINES * 8);
		done  = 1'b0;
		tries = 0;
		while (!done) begin
			proc_command = cmd;
			proc_size    = mem_size_t'(size_v[1:0]);
			proc_addr    = addr_v[ADDR_W-1:0];
			proc_data    = wdata;
			@(posedge clk);
			#1;
			want = valid ? lowest_free_tag() : '0;
			check_tag("mem_response", mem_response, want);
			if (mem_response != '0) begin
				t               = int'(mem_response);
				accept_cycle[t] = cycle_cnt;
				is_load[t]      = (cmd == bus_load);
				exp_data[t]     = expected;
				if (cmd == bus_load) begin
					load_cnt[t] = load_cnt[t] + 1;
				end
				done = 1'b1;
			end else if (!valid) begin
				done = 1'b1;  // idle or out of range, never granted
			end else if (tries >= MAX_RETRY) begin
				$display("Command at address %h was still refused after %0d retries",
					addr_v, tries);
				stop_with_failure();
			end else begin
				refusals++;
				tries++;
			end
		end
	endtask

	initial begin
		int        fd;
		int        fields;
		int        lines_run;
		int        cmd_v;
		int        size_v;
		int        addr_v;
		int        wait_cnt;
		mem_data_t wdata_v;
		mem_data_t exp_v;
		string     line_str;

		arst_n       = 1'b0;
		proc_command = bus_none;
		proc_size    = size_double;
		proc_addr    = '0;
		proc_data    = '0;
		lines_run    = 0;

		////////////////////
		// reset
		////////////////////

		repeat (4) begin
			@(posedge clk);
			#1;
			check_tag("mem_response", mem_response, '0);
			check_tag("mem_tag", mem_tag, '0);
		end
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		check_tag("mem_response", mem_response, '0);
		check_tag("mem_tag", mem_tag, '0);

		////////////////////
		// stimulus
		////////////////////

		fd = $fopen("tb/tagged_mem_stimulus.dat", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file tb/tagged_mem_stimulus.dat");
			stop_with_failure();
		end
		while (!$feof(fd)) begin
			line_str = "";
			void'($fgets(line_str, fd));
			// comment and blank lines give fewer than five fields
			fields = $sscanf(line_str, "%h %h %h %h %h", cmd_v, size_v, addr_v, wdata_v, exp_v);
			if (fields == 5) begin
				issue_command(cmd_v, size_v, addr_v, wdata_v, exp_v);
				lines_run++;
			end
		end
		$fclose(fd);
		proc_command = bus_none;

		wait_cnt = 0;
		while (loads_outstanding() != 0) begin
			if (wait_cnt >= DRAIN_MAX) begin
				$display("%0d loads never came back on the data bus", loads_outstanding());
				stop_with_failure();
			end
			@(posedge clk);
			wait_cnt++;
		end

		if (lines_run == 0) begin
			$display("The stimulus file held no commands");
			stop_with_failure();
		end else if (refusals == 0) begin
			$display("No command was ever refused while all tags were busy");
			stop_with_failure();
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// File: tb/tagged_mem_stimulus.dat
// cmd size addr store_data expected_load, all fields hex
// cmd 0 none 1 load 2 store; size 0 byte 1 half 2 word 3 double; expected is 0 except for loads
0 3 0000 0000000000000000 0000000000000000
2 3 0000 0123456789abcdef 0000000000000000
1 3 0000 0000000000000000 0123456789abcdef
2 3 0008 0f0e0d0c0b0a0908 0000000000000000
1 3 0008 0000000000000000 0f0e0d0c0b0a0908
2 3 0010 fedcba9876543210 0000000000000000
2 0 0013 77777777777777a5 0000000000000000
2 1 0014 99999999ffff1234 0000000000000000
1 3 0010 0000000000000000 fedc1234a5543210
1 0 0013 0000000000000000 00000000000000a5
1 0 0017 0000000000000000 00000000000000fe
1 1 0014 0000000000000000 0000000000001234
1 1 0016 0000000000000000 000000000000fedc
1 2 0010 0000000000000000 00000000a5543210
1 2 0014 0000000000000000 00000000fedc1234
2 3 0018 8899aabbccddeeff 0000000000000000
2 2 001c 555555550badc0de 0000000000000000
1 3 0018 0000000000000000 0badc0deccddeeff
1 2 001c 0000000000000000 000000000badc0de
1 1 001a 0000000000000000 000000000000ccdd
1 0 0018 0000000000000000 00000000000000ff
1 1 001b 0000000000000000 000000000000ccdd
1 2 001e 0000000000000000 000000000badc0de
2 3 01f8 a1b2c3d4e5f60718 0000000000000000
1 0 01ff 0000000000000000 00000000000000a1
1 3 0200 0000000000000000 0000000000000000
2 3 fff8 5a5a5a5a5a5a5a5a 0000000000000000
1 3 01f8 0000000000000000 a1b2c3d4e5f60718
1 3 0000 0000000000000000 0123456789abcdef
1 3 0008 0000000000000000 0f0e0d0c0b0a0908
0 0 0000 0000000000000000 0000000000000000

// File: list.f
hdl/mem_pkg.sv
hdl/line_store.sv
hdl/tag_pool.sv
hdl/load_buffer.sv
hdl/tagged_mem.sv
tb/tagged_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tagged memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tagged_mem_tb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --top-module "$TOP" -f list.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG_FILE"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
